// File: dv/cache_dir_assert.sv
/*
 * Cache directory handshake and flush checks
 * Bound onto the top level from the testbench
 */
`timescale 1ns/100ps
`default_nettype none

module cache_dir_assert (
    input wire logic CLK,
    input wire logic arst_n,
    input wire logic req_valid,
    input wire logic req_ready,
    input wire logic resp_valid,
    input wire logic resp_ready,
    input wire logic resp_hit,
    input wire logic resp_used,
    input wire logic resp_wca,
    input wire logic flush_done
);

    // Response held under back-pressure
    resp_stable: assert property (@(posedge CLK) disable iff (!arst_n)
        resp_valid && !resp_ready |=> resp_valid && $stable({resp_hit, resp_used, resp_wca}))
        else $error("response changed while stalled");

    // No new request while one is in flight
    busy_after_req: assert property (@(posedge CLK) disable iff (!arst_n)
        req_valid && req_ready |=> !req_ready)
        else $error("req_ready high in lookup");
    busy_in_update: assert property (@(posedge CLK) disable iff (!arst_n)
        resp_valid && resp_ready |=> !req_ready)
        else $error("req_ready high in update");

    flush_pulse: assert property (@(posedge CLK) disable iff (!arst_n)
        flush_done |=> !flush_done)
        else $error("flush_done longer than one cycle");

endmodule

`default_nettype wire

// File: dv/cache_dir_tb.sv
/*
 * Cache directory controller testbench
 * Table of requests checked against hand values and a directory model
 */
`timescale 1ns/100ps
`include "cache_defines.svh"
`default_nettype none

module cache_dir_tb;

    localparam int MAX_STALL = 5;       // Longest resp_ready stall
    localparam int SEED      = 70592;
    localparam int ADDR_W    = `CACHE_TAG_W + `CACHE_INDEX_W;

    typedef struct packed {
        logic               flush_first;    // Flush the directory before this row
        cache_pkg::cyc_op_e op;
        logic [ADDR_W-1:0]  addr;           // {tag, index}
        logic               shadow;
        logic               fmiss;
        logic               en;
        logic               hit;
        logic               used;
        logic               wca;
    } test_row_t;

    logic               CLK;
    logic               arst_n;
    logic               req_valid;
    logic               req_ready;
    cache_pkg::cyc_op_e req_op;
    logic [ADDR_W-1:0]  req_addr;
    logic               req_shadow;
    logic               req_fmiss;
    logic               cache_en;
    logic               resp_valid;
    logic               resp_ready;
    logic               resp_hit;
    logic               resp_used;
    logic               resp_wca;
    logic               flush_req;
    logic               flush_done;

    test_row_t         rows[$];
    int                errors = 0;
    int                cycle_cnt = 0;
    int                timeout_limit = 100000;  // Replaced once the table is built
    // Reference directory
    logic              m_valid [`CACHE_LINES];
    logic [`CACHE_TAG_W-1:0] m_tag [`CACHE_LINES];
    logic              m_ubi [`CACHE_LINES];
    logic              m_ubd [`CACHE_LINES];

    cache_dir_top cache_dir_top_i (.*);

    bind cache_dir_top cache_dir_assert cache_dir_assert_i (
        .CLK(CLK), .arst_n(arst_n), .req_valid(req_valid), .req_ready(req_ready),
        .resp_valid(resp_valid), .resp_ready(resp_ready), .resp_hit(resp_hit),
        .resp_used(resp_used), .resp_wca(resp_wca), .flush_done(flush_done)
    );

    initial CLK = 1'b0;
    always #50 CLK = ~CLK;              // 100 ns period

    // Run limit scaled by table length
    always @(posedge CLK) begin
        cycle_cnt++;
        if (cycle_cnt > timeout_limit) begin
            $display("Timeout: run stopped after %0d cycles", cycle_cnt);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic compare_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_op(input string name, input cache_pkg::cyc_op_e got,
                              input cache_pkg::cyc_op_e exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic add_row(input logic fl, input cache_pkg::cyc_op_e op,
                           input logic [ADDR_W-1:0] addr, input logic sh, input logic fm,
                           input logic en, input logic hit, input logic used,
                           input logic wca);
        rows.push_back({fl, op, addr, sh, fm, en, hit, used, wca});
    endtask

    // Expected flags from the decision rules
    task automatic predict_response(input test_row_t row, output logic hit,
                                    output logic used, output logic wca);
        logic [`CACHE_INDEX_W-1:0] idx;
        logic                      tag_hit;
        logic                      enabled;
        idx     = row.addr[`CACHE_INDEX_W-1:0];
        tag_hit = m_valid[idx] && (m_tag[idx] == row.addr[ADDR_W-1:`CACHE_INDEX_W]);
        enabled = row.en && !row.shadow && !row.fmiss;
        used    = (row.op == cache_pkg::OP_FETCH) ? m_ubi[idx] :
                  (row.op == cache_pkg::OP_READ)  ? m_ubd[idx] : 1'b0;
        wca     = enabled && (row.op == cache_pkg::OP_WRITE || !(tag_hit && used));
        hit     = tag_hit && used && !wca;
    endtask

    task automatic apply_update(input test_row_t row, input logic wca);
        logic [`CACHE_INDEX_W-1:0] idx;
        logic [`CACHE_TAG_W-1:0]   tag;
        idx = row.addr[`CACHE_INDEX_W-1:0];
        tag = row.addr[ADDR_W-1:`CACHE_INDEX_W];
        if (wca) begin                  // Allocate, owner kind takes the line
            m_valid[idx] = 1'b1;
            m_tag[idx]   = tag;
            m_ubi[idx]   = (row.op == cache_pkg::OP_FETCH);
            m_ubd[idx]   = (row.op != cache_pkg::OP_FETCH);
        end else if (row.op == cache_pkg::OP_WRITE && m_valid[idx] && m_tag[idx] == tag) begin
            m_ubi[idx] = 1'b0;          // Write hit drops both used bits
            m_ubd[idx] = 1'b0;
        end
    endtask

    task automatic clear_directory();
        for (int i = 0; i < `CACHE_LINES; i++) begin
            m_valid[i] = 1'b0;
            m_ubi[i]   = 1'b0;
            m_ubd[i]   = 1'b0;
        end
    endtask

    // One request through lookup, response and update
    task automatic run_request(input int num, input test_row_t row, input int stall);
        logic hit_q;
        logic used_q;
        logic wca_q;
        int   lat;
        @(negedge CLK);
        while (!req_ready) @(negedge CLK);
        req_op     = row.op;
        req_addr   = row.addr;
        req_shadow = row.shadow;
        req_fmiss  = row.fmiss;
        cache_en   = row.en;
        req_valid  = 1'b1;
        @(negedge CLK);                 // Transfer on the edge just passed
        req_valid = 1'b0;
        compare_op("op_q", cache_dir_top_i.used_bits_ctrl_i.op_q, row.op);
        lat = 1;
        while (!resp_valid && lat < 8) begin
            @(negedge CLK);
            lat++;
        end
        if (!resp_valid) begin
            $display("Test %0d: no response within %0d cycles", num, lat);
            errors++;
            return;
        end
        if (lat != 2) begin
            $display("Test %0d: response after %0d cycles instead of 2", num, lat);
            errors++;
        end
        compare_flag("resp_hit", resp_hit, row.hit);
        compare_flag("resp_used", resp_used, row.used);
        compare_flag("resp_wca", resp_wca, row.wca);
        hit_q  = resp_hit;
        used_q = resp_used;
        wca_q  = resp_wca;
        repeat (stall) begin            // Back-pressure
            @(negedge CLK);
            if (!resp_valid) begin
                $display("Test %0d: resp_valid dropped during stall", num);
                errors++;
            end
            compare_flag("resp_hit", resp_hit, hit_q);
            compare_flag("resp_used", resp_used, used_q);
            compare_flag("resp_wca", resp_wca, wca_q);
        end
        resp_ready = 1'b1;
        @(negedge CLK);                 // Now in update
        resp_ready = 1'b0;
    endtask

    task automatic run_flush(input int num);
        int cnt;
        @(negedge CLK);
        while (!req_ready) @(negedge CLK);
        flush_req = 1'b1;               // Single-cycle pulse
        @(negedge CLK);
        flush_req = 1'b0;
        cnt = 1;
        while (!flush_done && cnt < 2 * `CACHE_LINES) begin
            @(negedge CLK);
            cnt++;
        end
        if (!flush_done) begin
            $display("Test %0d: flush_done never came", num);
            errors++;
        end else if (cnt != `CACHE_LINES) begin
            $display("Test %0d: flush took %0d cycles, expected %0d", num, cnt, `CACHE_LINES);
            errors++;
        end
        clear_directory();
    endtask

    initial begin
        logic exp_hit;
        logic exp_used;
        logic exp_wca;
        int   stall;
        int   errs_before;
        test_row_t row;
        arst_n     = 1'b0;
        req_valid  = 1'b0;
        req_op     = cache_pkg::OP_FETCH;
        req_addr   = '0;
        req_shadow = 1'b0;
        req_fmiss  = 1'b0;
        cache_en   = 1'b0;
        resp_ready = 1'b0;
        flush_req  = 1'b0;
        void'($urandom(SEED));
        clear_directory();

        // fl  op                    addr     sh fm en  hit used wca
        add_row(0, cache_pkg::OP_FETCH, 12'h123, 0, 0, 1, 0, 0, 1);  // Cold miss
        add_row(0, cache_pkg::OP_FETCH, 12'h123, 0, 0, 1, 1, 1, 0);
        add_row(0, cache_pkg::OP_READ,  12'h123, 0, 0, 1, 0, 0, 1);  // Data on code line
        add_row(0, cache_pkg::OP_FETCH, 12'h123, 0, 0, 1, 0, 0, 1);
        add_row(0, cache_pkg::OP_READ,  12'h455, 0, 0, 1, 0, 0, 1);
        add_row(0, cache_pkg::OP_READ,  12'h455, 0, 0, 1, 1, 1, 0);
        add_row(0, cache_pkg::OP_WRITE, 12'h455, 0, 1, 1, 0, 0, 0);  // fmiss write hit
        add_row(0, cache_pkg::OP_READ,  12'h455, 0, 0, 1, 0, 0, 1);
        add_row(0, cache_pkg::OP_READ,  12'h455, 0, 0, 1, 1, 1, 0);
        add_row(0, cache_pkg::OP_WRITE, 12'h455, 1, 0, 1, 0, 0, 0);  // Shadow write hit
        add_row(0, cache_pkg::OP_READ,  12'h455, 1, 0, 1, 0, 0, 0);
        add_row(0, cache_pkg::OP_READ,  12'h455, 0, 0, 1, 0, 0, 1);
        add_row(0, cache_pkg::OP_WRITE, 12'h455, 0, 0, 0, 0, 0, 0);  // Cache off
        add_row(0, cache_pkg::OP_WRITE, 12'h455, 0, 0, 1, 0, 0, 1);
        add_row(0, cache_pkg::OP_READ,  12'h455, 0, 0, 1, 1, 1, 0);
        add_row(0, cache_pkg::OP_FETCH, 12'h153, 0, 0, 1, 0, 1, 1);  // Upper half matches only
        add_row(0, cache_pkg::OP_FETCH, 12'h123, 0, 0, 1, 0, 1, 1);
        add_row(0, cache_pkg::OP_FETCH, 12'h123, 0, 0, 1, 1, 1, 0);
        add_row(1, cache_pkg::OP_FETCH, 12'h123, 0, 0, 1, 0, 0, 1);  // After flush
        add_row(0, cache_pkg::OP_READ,  12'h455, 0, 0, 1, 0, 0, 1);
        add_row(0, cache_pkg::OP_READ,  12'h2a7, 0, 0, 0, 0, 0, 0);
        timeout_limit = 4 * rows.size() * (4 + MAX_STALL) + `CACHE_LINES;

        repeat (4) @(negedge CLK);
        arst_n = 1'b1;
        compare_flag("req_ready", req_ready, 1'b1);     // Reset values
        compare_flag("resp_valid", resp_valid, 1'b0);
        compare_flag("flush_done", flush_done, 1'b0);

        foreach (rows[i]) begin
            row         = rows[i];
            errs_before = errors;
            stall       = $urandom % (MAX_STALL + 1);
            if (row.flush_first) run_flush(i);
            predict_response(row, exp_hit, exp_used, exp_wca);
            if ({exp_hit, exp_used, exp_wca} !== {row.hit, row.used, row.wca}) begin
                $display("Test %0d: table row disagrees with the reference model", i);
                errors++;
            end
            run_request(i, row, stall);
            apply_update(row, row.wca);
            $display("Test %0d: op=%0d addr=0x%h stall=%0d %s", i, row.op, row.addr, stall,
                     (errors == errs_before) ? "ok" : "FAILED");
        end

        $display("Tests run: %0d, errors: %0d", rows.size(), errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/cache_defines.svh
/*
 * Cache directory size definitions
 * Index, tag and line count shared by the directory RTL
 */
`default_nettype none

`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// Line index into the directory
`define CACHE_INDEX_W 4

// Full tag, compared as two equal halves
`define CACHE_TAG_W 8

// One line per index value
`define CACHE_LINES (1 << `CACHE_INDEX_W)

`endif

`default_nettype wire

// File: logic/cache_dir_top.sv
/*
 * Cache directory controller top level
 * Sequencer, flush counter, directory and used-bit logic
 */
`timescale 1ns/100ps
`include "cache_defines.svh"
`default_nettype none

module cache_dir_top (
    input  wire logic                                  CLK,
    input  wire logic                                  arst_n,
    // Request channel
    input  wire logic                                  req_valid,
    output logic                                       req_ready,
    input  wire cache_pkg::cyc_op_e                     req_op,
    input  wire logic [`CACHE_TAG_W+`CACHE_INDEX_W-1:0] req_addr,
    input  wire logic                                  req_shadow,
    input  wire logic                                  req_fmiss,
    input  wire logic                                  cache_en,
    // Response channel
    output logic                                       resp_valid,
    input  wire logic                                  resp_ready,
    output logic                                       resp_hit,
    output logic                                       resp_used,
    output logic                                       resp_wca,
    // Flush
    input  wire logic                                  flush_req,
    output logic                                       flush_done
);

    logic                      lookup_en;
    logic                      update_en;
    logic                      flush_en;
    logic                      cnt_clr;
    logic [`CACHE_INDEX_W-1:0] flush_index;
    logic                      last_line;
    logic                      hit0;
    logic                      hit1;
    logic                      line_valid;
    logic                      oubi;
    logic                      oubd;
    logic                      ntag_we;
    logic                      nused_we;
    logic                      nvalid;
    logic                      nubi;
    logic                      nubd;

    cache_seq cache_seq_i (
        .CLK        (CLK),
        .arst_n     (arst_n),
        .req_valid  (req_valid),
        .resp_ready (resp_ready),
        .flush_req  (flush_req),
        .last_line  (last_line),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .lookup_en  (lookup_en),
        .update_en  (update_en),
        .flush_en   (flush_en),
        .cnt_clr    (cnt_clr),
        .flush_done (flush_done)
    );

    line_counter line_counter_i (
        .CLK         (CLK),
        .arst_n      (arst_n),
        .cnt_clr     (cnt_clr),
        .flush_en    (flush_en),
        .flush_index (flush_index),
        .last_line   (last_line)
    );

    cache_directory cache_directory_i (
        .CLK         (CLK),
        .arst_n      (arst_n),
        .lookup_en   (lookup_en),
        .req_addr    (req_addr),
        .flush_en    (flush_en),
        .flush_index (flush_index),
        .ntag_we     (ntag_we),
        .nused_we    (nused_we),
        .nvalid      (nvalid),
        .nubi        (nubi),
        .nubd        (nubd),
        .hit0        (hit0),
        .hit1        (hit1),
        .oubi        (oubi),
        .oubd        (oubd),
        .line_valid  (line_valid)
    );

    used_bits_ctrl used_bits_ctrl_i (
        .CLK        (CLK),
        .arst_n     (arst_n),
        .lookup_en  (lookup_en),
        .update_en  (update_en),
        .req_op     (req_op),
        .req_shadow (req_shadow),
        .req_fmiss  (req_fmiss),
        .cache_en   (cache_en),
        .hit0       (hit0),
        .hit1       (hit1),
        .line_valid (line_valid),
        .oubi       (oubi),
        .oubd       (oubd),
        .resp_hit   (resp_hit),
        .resp_used  (resp_used),
        .resp_wca   (resp_wca),
        .ntag_we    (ntag_we),
        .nused_we   (nused_we),
        .nvalid     (nvalid),
        .nubi       (nubi),
        .nubd       (nubd)
    );

endmodule

`default_nettype wire

// File: logic/cache_directory.sv
/*
 * Cache directory storage
 * Per-line tag, valid and used bits, split tag compare
 * and the write-back and flush ports
 */
`timescale 1ns/100ps
`include "cache_defines.svh"
`default_nettype none

module cache_directory (
    input  wire logic                                  CLK,
    input  wire logic                                  arst_n,
    input  wire logic                                  lookup_en,
    input  wire logic [`CACHE_TAG_W+`CACHE_INDEX_W-1:0] req_addr,
    input  wire logic                                  flush_en,
    input  wire logic [`CACHE_INDEX_W-1:0]             flush_index,
    input  wire logic                                  ntag_we,
    input  wire logic                                  nused_we,
    input  wire logic                                  nvalid,
    input  wire logic                                  nubi,
    input  wire logic                                  nubd,
    output logic                                       hit0,
    output logic                                       hit1,
    output logic                                       oubi,
    output logic                                       oubd,
    output logic                                       line_valid
);

    localparam int HALF_W = `CACHE_TAG_W / 2;

    logic [`CACHE_INDEX_W-1:0] idx_q;                  // Registered line index
    logic [`CACHE_TAG_W-1:0]   tag_q;                  // Registered request tag
    logic [`CACHE_TAG_W-1:0]   tag_mem [`CACHE_LINES];
    logic [`CACHE_LINES-1:0]   valid_q;
    logic [`CACHE_LINES-1:0]   ubi_q;                  // Instruction used bits
    logic [`CACHE_LINES-1:0]   ubd_q;                  // Data used bits
    logic [`CACHE_TAG_W-1:0]   line_tag;

    // Address split as {tag, index}
    always_ff @(posedge CLK) begin
        if (lookup_en) begin
            idx_q <= req_addr[`CACHE_INDEX_W-1:0];
            tag_q <= req_addr[`CACHE_TAG_W+`CACHE_INDEX_W-1:`CACHE_INDEX_W];
        end
    end

    // Tag RAM, written only on allocate
    always_ff @(posedge CLK) begin
        if (ntag_we) begin
            tag_mem[idx_q] <= tag_q;
        end
    end

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
            ubi_q   <= '0;
            ubd_q   <= '0;
        end else if (flush_en) begin
            // Sweep clears one line per cycle
            valid_q[flush_index] <= 1'b0;
            ubi_q[flush_index]   <= 1'b0;
            ubd_q[flush_index]   <= 1'b0;
        end else begin
            if (ntag_we) valid_q[idx_q] <= nvalid;
            if (nused_we) begin
                ubi_q[idx_q] <= nubi;
                ubd_q[idx_q] <= nubd;
            end
        end
    end

    assign line_tag = tag_mem[idx_q];

    // Two half comparators, like the original board
    assign hit0 = (line_tag[HALF_W-1:0] == tag_q[HALF_W-1:0]);
    assign hit1 = (line_tag[`CACHE_TAG_W-1:HALF_W] == tag_q[`CACHE_TAG_W-1:HALF_W]);

    assign line_valid = valid_q[idx_q];
    assign oubi       = ubi_q[idx_q];
    assign oubd       = ubd_q[idx_q];

endmodule

`default_nettype wire

// File: logic/cache_pkg.sv
/*
 * Cache directory package
 * Cycle opcodes and sequencer states
 */
`default_nettype none

package cache_pkg;

    // Cycle type of a request
    typedef enum logic [1:0] {
        OP_FETCH = 2'd0,    // Instruction fetch
        OP_READ  = 2'd1,    // Data read
        OP_WRITE = 2'd2     // Data write
    } cyc_op_e;

    // Sequencer states
    typedef enum logic [2:0] {
        ST_IDLE   = 3'd0,   // Waiting for request or flush
        ST_LOOKUP = 3'd1,   // Tag compare, flags register at end
        ST_RESP   = 3'd2,   // Response offered
        ST_UPDATE = 3'd3,   // Directory write-back
        ST_FLUSH  = 3'd4    // Line sweep
    } seq_state_e;

endpackage

`default_nettype wire

// File: logic/cache_seq.sv
/*
 * Cache directory sequencer
 * Runs lookup, response hand-off, update and flush,
 * and holds a flush request that arrives while busy
 */
`timescale 1ns/100ps
`default_nettype none

module cache_seq (
    input  wire logic CLK,
    input  wire logic arst_n,
    input  wire logic req_valid,
    input  wire logic resp_ready,
    input  wire logic flush_req,
    input  wire logic last_line,
    output logic      req_ready,
    output logic      resp_valid,
    output logic      lookup_en,
    output logic      update_en,
    output logic      flush_en,
    output logic      cnt_clr,
    output logic      flush_done
);

    cache_pkg::seq_state_e state_q;
    cache_pkg::seq_state_e state_d;
    logic flush_pend;           // Flush waiting for idle
    logic start_flush;

    // Requests win over a flush in the same idle cycle
    assign start_flush = (state_q == cache_pkg::ST_IDLE) & ~req_valid
                         & (flush_req | flush_pend);

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            cache_pkg::ST_IDLE: begin
                if (req_valid) state_d = cache_pkg::ST_LOOKUP;     // Request transfer
                else if (start_flush) state_d = cache_pkg::ST_FLUSH;
            end
            cache_pkg::ST_LOOKUP: state_d = cache_pkg::ST_RESP;
            cache_pkg::ST_RESP: begin
                if (resp_ready) state_d = cache_pkg::ST_UPDATE;    // Response transfer
            end
            cache_pkg::ST_UPDATE: state_d = cache_pkg::ST_IDLE;
            cache_pkg::ST_FLUSH: begin
                if (last_line) state_d = cache_pkg::ST_IDLE;
            end
            default: state_d = cache_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            state_q    <= cache_pkg::ST_IDLE;
            flush_pend <= 1'b0;
        end else begin
            state_q    <= state_d;
            flush_pend <= (flush_pend | flush_req) & ~start_flush;
        end
    end

    // Handshakes and strobes decoded from state
    assign req_ready  = (state_q == cache_pkg::ST_IDLE);
    assign lookup_en  = req_ready & req_valid;          // Capture at transfer edge
    assign resp_valid = (state_q == cache_pkg::ST_RESP);
    assign update_en  = (state_q == cache_pkg::ST_UPDATE);
    assign flush_en   = (state_q == cache_pkg::ST_FLUSH);
    assign cnt_clr    = start_flush;                    // Counter from line 0
    assign flush_done = flush_en & last_line;           // One cycle, last line

endmodule

`default_nettype wire

// File: logic/line_counter.sv
/*
 * Flush line counter
 * Steps the directory index once per flush cycle
 */
`timescale 1ns/100ps
`include "cache_defines.svh"
`default_nettype none

module line_counter (
    input  wire logic                      CLK,
    input  wire logic                      arst_n,
    input  wire logic                      cnt_clr,
    input  wire logic                      flush_en,
    output logic [`CACHE_INDEX_W-1:0]      flush_index,
    output logic                           last_line
);

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            flush_index <= '0;
        end else if (cnt_clr) begin
            flush_index <= '0;                  // Start of a sweep
        end else if (flush_en) begin
            flush_index <= flush_index + 1'b1;  // Wraps to zero after the last line
        end
    end

    // Terminal count
    assign last_line = (flush_index == `CACHE_INDEX_W'(`CACHE_LINES - 1));

endmodule

`default_nettype wire

// File: logic/used_bits_ctrl.sv
/*
 * Used-bit decision logic
 * Works out hit, used and write-allocate for a lookup and
 * the new valid, ubi and ubd values for the directory
 */
`timescale 1ns/100ps
`default_nettype none

module used_bits_ctrl (
    input  wire logic              CLK,
    input  wire logic              arst_n,
    input  wire logic              lookup_en,
    input  wire logic              update_en,
    input  wire cache_pkg::cyc_op_e req_op,
    input  wire logic              req_shadow,
    input  wire logic              req_fmiss,
    input  wire logic              cache_en,
    input  wire logic              hit0,
    input  wire logic              hit1,
    input  wire logic              line_valid,
    input  wire logic              oubi,
    input  wire logic              oubd,
    output logic                   resp_hit,
    output logic                   resp_used,
    output logic                   resp_wca,
    output logic                   ntag_we,
    output logic                   nused_we,
    output logic                   nvalid,
    output logic                   nubi,
    output logic                   nubd
);

    cache_pkg::cyc_op_e op_q;   // Cycle type held for the whole request
    logic shadow_q;
    logic fmiss_q;
    logic en_q;
    logic lookup_q;             // High during ST_LOOKUP
    logic tag_hit_q;
    logic tag_hit;
    logic enabled;
    logic is_fetch;
    logic is_read;
    logic is_write;
    logic used_c;
    logic wca_c;

    // Request qualifiers taken with the address
    always_ff @(posedge CLK) begin
        if (lookup_en) begin
            op_q     <= req_op;
            shadow_q <= req_shadow;
            fmiss_q  <= req_fmiss;
            en_q     <= cache_en;
        end
    end

    assign is_fetch = (op_q == cache_pkg::OP_FETCH);
    assign is_read  = (op_q == cache_pkg::OP_READ);
    assign is_write = (op_q == cache_pkg::OP_WRITE);

    assign tag_hit = line_valid & hit0 & hit1;     // Both halves on a valid line
    assign enabled = en_q & ~shadow_q & ~fmiss_q;

    // Used bit of the cycle's own kind, none for writes
    assign used_c = (is_fetch & oubi) | (is_read & oubd);

    // Allocate on enabled write, or enabled fetch/read without a used hit
    assign wca_c = enabled & (is_write | ~(tag_hit & used_c));

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            lookup_q  <= 1'b0;
            resp_hit  <= 1'b0;
            resp_used <= 1'b0;
            resp_wca  <= 1'b0;
            tag_hit_q <= 1'b0;
        end else begin
            lookup_q <= lookup_en;
            if (lookup_q) begin                 // End of ST_LOOKUP
                resp_hit  <= tag_hit & used_c & ~wca_c;
                resp_used <= used_c;
                resp_wca  <= wca_c;
                tag_hit_q <= tag_hit;
            end
        end
    end

    // Write-back, only strobed in ST_UPDATE
    assign ntag_we  = update_en & resp_wca;                        // New tag on allocate
    assign nused_we = update_en & (resp_wca | (is_write & tag_hit_q));
    assign nvalid   = resp_wca;
    assign nubi     = resp_wca & is_fetch;     // Fetch owns the line for code
    assign nubd     = resp_wca & ~is_fetch;    // Read/write owns it for data
    // Write hit without allocate leaves both bits low

endmodule

`default_nettype wire

// File: vlog.f
+incdir+logic
logic/cache_pkg.sv
logic/line_counter.sv
logic/cache_directory.sv
logic/used_bits_ctrl.sv
logic/cache_seq.sv
logic/cache_dir_top.sv
dv/cache_dir_assert.sv
dv/cache_dir_tb.sv
